// ==== common/bist_pkg.sv ====
// Run control for the BIST wrapper. The pattern count per run is fixed at build time
// and the counter width must hold PATTERNS_PER_RUN

package bist_pkg;

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    localparam int DATA_WIDTH       = 32; // Pattern, response and signature width
    localparam int PATTERNS_PER_RUN = 6;
    localparam int COUNT_WIDTH      = 3;  // Holds 0 to PATTERNS_PER_RUN

    typedef logic [COUNT_WIDTH-1:0] count_t;

    //////////////////////////////////////////////////
    // Sequencer state
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE     = 2'b00, // Waiting for a host request
        GEN_VAL  = 2'b01, // Pattern offered to the circuit
        SEND_VAL = 2'b10  // Response sampled
    } seq_state_e;

    //////////////////////////////////////////////////
    // Host request and run result
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [DATA_WIDTH-1:0] seed; // Zero selects the default seed
    } bist_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] signature;
    } bist_result_t;

endpackage

// ==== common/lfsr_pkg.sv ====
// Galois arithmetic for x^32+x^22+x^2+x+1, shifting right
// Compile after bist_pkg, which gives the word width

package lfsr_pkg;

    // One bit per polynomial term x^k at position k-1
    localparam logic [bist_pkg::DATA_WIDTH-1:0] LFSR_TAPS = 32'h8020_0003;

    // An all-zero state never leaves zero
    localparam logic [bist_pkg::DATA_WIDTH-1:0] LFSR_DEFAULT_SEED = 32'h0000_0001;

    // One Galois step. The feedback is the bit shifted out
    function automatic logic [bist_pkg::DATA_WIDTH-1:0] lfsr_step(
        input logic [bist_pkg::DATA_WIDTH-1:0] value
    );
        logic [bist_pkg::DATA_WIDTH-1:0] shifted;
        shifted = value >> 1;
        if (value[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

endpackage

// ==== bist/bist_sequencer.sv ====
// Run sequencer with exactly PATTERNS_PER_RUN patterns per run
// Host requests are ignored unless the sequencer is idle

`timescale 1ns/1ps

module bist_sequencer (
    input  logic clk,
    input  logic reset,

    // Host handshake
    input  logic req_val,
    output logic req_rdy,

    // Circuit handshake
    output logic resq_val,
    input  logic resq_rdy,

    // Strobes to generator and compactor
    output logic start,
    output logic absorb,
    output logic finish
);

    bist_pkg::seq_state_e state;
    bist_pkg::seq_state_e next_state;
    bist_pkg::count_t     count;     // SEND_VAL cycles done this run
    logic                 last_pattern;

    //////////////////////////////////////////////////
    // Output decode
    //////////////////////////////////////////////////

    assign req_rdy  = (state == bist_pkg::IDLE);
    assign resq_val = (state == bist_pkg::GEN_VAL);
    assign absorb   = (state == bist_pkg::SEND_VAL);
    assign start    = req_val && req_rdy; // Accept condition

    // Count still excludes the SEND_VAL cycle in progress
    assign last_pattern = (count == bist_pkg::count_t'(bist_pkg::PATTERNS_PER_RUN - 1));
    assign finish       = absorb && last_pattern;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            bist_pkg::IDLE: begin
                if (start) begin
                    next_state = bist_pkg::GEN_VAL;
                end
            end
            bist_pkg::GEN_VAL: begin
                if (resq_rdy) begin // Hold under back-pressure
                    next_state = bist_pkg::SEND_VAL;
                end
            end
            bist_pkg::SEND_VAL: begin
                if (last_pattern) begin
                    next_state = bist_pkg::IDLE;
                end else begin
                    next_state = bist_pkg::GEN_VAL;
                end
            end
            default: begin
                next_state = bist_pkg::IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // State and pattern counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bist_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= '0; // New run
        end else if (absorb) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== bist/lfsr_pattern_gen.sv ====
// Pattern source for the circuit under test
// The pattern only moves on start or absorb so it is stable under back-pressure

`timescale 1ns/1ps

module lfsr_pattern_gen (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            absorb,
    input  bist_pkg::bist_req_t             seed_req,
    output logic [bist_pkg::DATA_WIDTH-1:0] pattern
);

    logic [bist_pkg::DATA_WIDTH-1:0] load_value;

    // A zero seed would lock the register at zero
    always_comb begin
        if (seed_req.seed == '0) begin
            load_value = lfsr_pkg::LFSR_DEFAULT_SEED;
        end else begin
            load_value = seed_req.seed;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pattern <= '0;
        end else if (start) begin
            pattern <= load_value;
        end else if (absorb) begin
            pattern <= lfsr_pkg::lfsr_step(pattern); // Next pattern after each response
        end
    end

endmodule

// ==== bist/response_misr.sv ====
// Signature register folding one circuit response per absorb strobe
// The result holds after done until the next start clears it

`timescale 1ns/1ps

module response_misr (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            absorb,
    input  logic                            finish,
    input  logic [bist_pkg::DATA_WIDTH-1:0] response,
    output logic                            done,
    output bist_pkg::bist_result_t          result
);

    //////////////////////////////////////////////////
    // Signature
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (start) begin
            result <= '0;
        end else if (absorb) begin
            result.signature <= lfsr_pkg::lfsr_step(result.signature) ^ response;
        end
    end

    //////////////////////////////////////////////////
    // Done pulse
    //////////////////////////////////////////////////

    // Lines up with the last signature update
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

endmodule

// ==== source/bist_top.sv ====
// BIST wrapper top. The circuit under test sits outside on the resq ports
// and must hold its response through the SEND_VAL cycle after each transfer

`timescale 1ns/1ps

module bist_top (
    input  logic                            clk,
    input  logic                            reset,

    // Host
    input  logic                            req_val,
    output logic                            req_rdy,
    input  bist_pkg::bist_req_t             req,

    // Circuit under test
    output logic                            resq_val,
    input  logic                            resq_rdy,
    output logic [bist_pkg::DATA_WIDTH-1:0] pattern,
    input  logic [bist_pkg::DATA_WIDTH-1:0] response,

    // Result
    output logic                            done,
    output bist_pkg::bist_result_t          result
);

    logic start;
    logic absorb;
    logic finish;

    bist_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .req_val  (req_val),
        .req_rdy  (req_rdy),
        .resq_val (resq_val),
        .resq_rdy (resq_rdy),
        .start    (start),
        .absorb   (absorb),
        .finish   (finish)
    );

    lfsr_pattern_gen u_pattern_gen (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .absorb   (absorb),
        .seed_req (req),
        .pattern  (pattern)
    );

    response_misr u_misr (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .absorb   (absorb),
        .finish   (finish),
        .response (response),
        .done     (done),
        .result   (result)
    );

endmodule

// ==== test/bist_checker.sv ====
// Handshake and strobe rules of bist_top, attached by bind
// Each flag stays set after its assertion fails

`timescale 1ns/1ps

module bist_checker (
    input logic                            clk,
    input logic                            reset,
    input logic                            req_rdy,
    input logic                            resq_val,
    input logic                            resq_rdy,
    input logic [bist_pkg::DATA_WIDTH-1:0] pattern,
    input logic                            done
);

    logic rdy_fail    = 1'b0;
    logic hold_fail   = 1'b0;
    logic pulse_fail  = 1'b0;
    logic any_failed;

    assign any_failed = rdy_fail | hold_fail | pulse_fail;

    //////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////

    a_rdy_excl: assert property (@(posedge clk) disable iff (reset)
        !(req_rdy && resq_val))
    else begin
        rdy_fail = 1'b1;
        $error("req_rdy and resq_val high together");
    end

    a_pattern_hold: assert property (@(posedge clk) disable iff (reset)
        (resq_val && !resq_rdy) |=> $stable(pattern))
    else begin
        hold_fail = 1'b1;
        $error("pattern moved under back-pressure");
    end

    //////////////////////////////////////////////////
    // Done pulse
    //////////////////////////////////////////////////

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else begin
        pulse_fail = 1'b1;
        $error("done longer than one cycle");
    end

endmodule

bind bist_top bist_checker u_checker (
    .clk      (clk),
    .reset    (reset),
    .req_rdy  (req_rdy),
    .resq_val (resq_val),
    .resq_rdy (resq_rdy),
    .pattern  (pattern),
    .done     (done)
);

// ==== test/bist_tb.sv ====
// Testbench for bist_top with a circuit model and a reference model of the LFSR and MISR
// Runs come from a table; the first error stops the run

`timescale 1ns/1ps

module bist_tb;

    typedef logic [bist_pkg::DATA_WIDTH-1:0] word_t;
    typedef enum logic [1:0] {STALL_NONE, STALL_FIXED, STALL_RANDOM} stall_mode_e;

    typedef struct packed {
        bist_pkg::bist_req_t    req;
        stall_mode_e            stall;
        logic                   busy_req; // Extra request while the run is busy
        bist_pkg::bist_result_t expected;
    } run_row_t;

    localparam int          NUM_RUNS     = 8;
    localparam int          WAIT_LIMIT   = 200;
    localparam logic [31:0] RANDOM_SEED  = 32'hf17d64d0;
    localparam word_t       MODEL_TAPS   = 32'h8020_0003; // x^32+x^22+x^2+x+1
    localparam word_t       MODEL_DEFAULT = 32'h0000_0001;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   req_val = 1'b0;
    logic                   req_rdy;
    bist_pkg::bist_req_t    req = '0;
    logic                   resq_val;
    logic                   resq_rdy = 1'b0;
    word_t                  pattern;
    word_t                  response = '0;
    logic                   done;
    bist_pkg::bist_result_t result;

    run_row_t    run_table [NUM_RUNS];
    word_t       exp_patterns [bist_pkg::PATTERNS_PER_RUN];
    stall_mode_e stall_mode = STALL_NONE;
    int          stall_left = 0;
    int          xfer_index = 0;
    int          done_count = 0;

    bist_top dut (
        .clk      (clk),
        .reset    (reset),
        .req_val  (req_val),
        .req_rdy  (req_rdy),
        .req      (req),
        .resq_val (resq_val),
        .resq_rdy (resq_rdy),
        .pattern  (pattern),
        .response (response),
        .done     (done),
        .result   (result)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic word_t model_step(input word_t value);
        return (value >> 1) ^ (value[0] ? MODEL_TAPS : 32'h0);
    endfunction

    function automatic word_t model_load(input word_t seed);
        return (seed == 32'h0) ? MODEL_DEFAULT : seed;
    endfunction

    function automatic word_t circuit_response(input word_t value);
        return {value[26:0], value[31:27]} ^ 32'hA5A5_0F0F; // Rotate left by 5
    endfunction

    function automatic word_t model_signature(input word_t seed);
        word_t p;
        word_t sig;
        p = model_load(seed);
        sig = 32'h0;
        for (int i = 0; i < bist_pkg::PATTERNS_PER_RUN; i++) begin
            sig = model_step(sig) ^ circuit_response(p);
            p = model_step(p);
        end
        return sig;
    endfunction

    function automatic int stall_cycles(input stall_mode_e mode);
        case (mode)
            STALL_NONE:  return 0;
            STALL_FIXED: return 2;
            default:     return int'($urandom % 32'd4);
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_pattern(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_result(input string name, input bist_pkg::bist_result_t actual,
                                input bist_pkg::bist_result_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual.signature, expected.signature));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Circuit model and done counter
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            resq_rdy   <= 1'b0;
            response   <= '0;
            xfer_index <= 0;
            stall_left = 0;
        end else if (req_val && req_rdy) begin
            xfer_index <= 0; // New run
            stall_left = stall_cycles(stall_mode);
            resq_rdy   <= (stall_left == 0);
        end else if (resq_val) begin
            if (xfer_index >= bist_pkg::PATTERNS_PER_RUN) begin
                report_failure("more patterns offered than one run allows");
            end
            check_pattern("pattern", pattern, exp_patterns[xfer_index]);
            if (resq_rdy) begin
                response   <= circuit_response(pattern);
                xfer_index <= xfer_index + 1;
                stall_left = stall_cycles(stall_mode);
                resq_rdy   <= (stall_left == 0);
            end else begin
                stall_left = stall_left - 1;
                resq_rdy   <= (stall_left == 0);
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        if (dut.u_checker.any_failed) begin
            report_failure("a handshake or strobe assertion failed");
        end
    end

    //////////////////////////////////////////////////
    // Waits and run sequencing
    //////////////////////////////////////////////////

    task automatic request(input bist_pkg::bist_req_t value);
        int   cycles;
        logic seen;
        req     <= value;
        req_val <= 1'b1;
        seen = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
            @(posedge clk);
            seen = req_rdy; // Accepted at this edge
        end
        if (!seen) begin
            report_failure("timeout waiting for req_rdy");
        end
        req_val <= 1'b0;
    endtask

    task automatic wait_for_resq_val();
        int   cycles;
        logic seen;
        seen = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
            @(posedge clk);
            seen = resq_val;
        end
        if (!seen) begin
            report_failure("timeout waiting for resq_val");
        end
    endtask

    task automatic wait_for_done();
        int   cycles;
        logic seen;
        seen = 1'b0;
        for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++) begin
            @(posedge clk);
            seen = done;
        end
        if (!seen) begin
            report_failure("timeout waiting for done");
        end
    endtask

    task automatic set_row(input int idx, input word_t seed, input stall_mode_e mode,
                           input logic busy);
        run_table[idx].req.seed           = seed;
        run_table[idx].stall              = mode;
        run_table[idx].busy_req           = busy;
        run_table[idx].expected.signature = model_signature(seed);
    endtask

    task automatic build_table();
        set_row(0, 32'h1234_5678, STALL_NONE, 1'b0);
        set_row(1, 32'h1234_5678, STALL_FIXED, 1'b0); // Same signature as row 0
        set_row(2, 32'h0000_0000, STALL_NONE, 1'b0);
        set_row(3, 32'h0000_0001, STALL_NONE, 1'b0);
        set_row(4, 32'hDEAD_BEEF, STALL_NONE, 1'b1);
        for (int i = 5; i < NUM_RUNS; i++) begin
            set_row(i, $urandom, STALL_RANDOM, 1'b0); // Back to back
        end
    endtask

    task automatic run_one(input int idx);
        run_row_t            row;
        bist_pkg::bist_req_t other;
        word_t               p;
        row = run_table[idx];
        p = model_load(row.req.seed);
        for (int i = 0; i < bist_pkg::PATTERNS_PER_RUN; i++) begin
            exp_patterns[i] = p;
            p = model_step(p);
        end
        stall_mode = row.stall;
        request(row.req);
        if (row.busy_req) begin
            wait_for_resq_val();
            other.seed = ~row.req.seed;
            req     <= other;
            req_val <= 1'b1;
            repeat (3) begin
                @(posedge clk);
                check_flag("req_rdy", req_rdy, 1'b0);
            end
            req_val <= 1'b0;
        end
        wait_for_done();
        check_count("done_count", done_count, idx);
        check_result("result", result, row.expected);
        check_count("transfers", xfer_index, bist_pkg::PATTERNS_PER_RUN);
        if (row.busy_req) begin
            repeat (4) @(posedge clk);
            check_count("done_count", done_count, idx + 1);
            check_flag("resq_val", resq_val, 1'b0); // No second run started
        end
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("req_rdy", req_rdy, 1'b1);
        check_flag("resq_val", resq_val, 1'b0);
        check_flag("done", done, 1'b0);
        check_pattern("pattern", pattern, 32'h0);
        check_result("result", result, '0);
        for (int i = 0; i < NUM_RUNS; i++) begin
            run_one(i);
        end
        repeat (4) @(posedge clk);
        if (dut.u_checker.any_failed) begin
            report_failure("a handshake or strobe assertion failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
common/bist_pkg.sv
common/lfsr_pkg.sv
bist/bist_sequencer.sv
bist/lfsr_pattern_gen.sv
bist/response_misr.sv
source/bist_top.sv
test/bist_checker.sv
test/bist_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the BIST testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module bist_tb -Mdir obj_dir

output=$(./obj_dir/Vbist_tb +verilator+error+limit+100 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
